//--- include/emesh_defines.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// eMesh sorter sizing macros
// Lane count, FIFO depth, field widths, lane select
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef EMESH_DEFINES_SVH
`define EMESH_DEFINES_SVH

// Lane structure
`define EM_LANES 4                   // Number of FIFO lanes
`define EM_LANE_W 2                  // Lane index width is log2 of EM_LANES

// FIFO sizing
`define EM_FIFO_AW 5                 // 32 entries per lane

// Packet fields
`define EM_ADDR_W 32                 // Transaction address
`define EM_PAYLOAD_W 32              // Data or return tag
`define EM_REQ_ID_W 4                // Requester id in the read tag
`define EM_PKT_W 65                  // Write flag + address + payload

// Write steering uses address bits starting here
`define EM_LANE_SEL_LSB 12           // 4 KB interleave across lanes

`endif

//--- source/emesh_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// eMesh sorter types
// Packet layout and the two payload decodings
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "emesh_defines.svh"

package emesh_pkg;

   // Return tag carried by a read request
   typedef struct packed
   {
      logic [`EM_REQ_ID_W-1:0]                 req_id;    // Requester id steers the lane
      logic [`EM_PAYLOAD_W-`EM_REQ_ID_W-1:0]   ret_addr;  // Where the response goes
   } em_rd_tag_t;

   // One payload word with two meanings picked by the write flag
   typedef union packed
   {
      logic [`EM_PAYLOAD_W-1:0]  wr_view;    // Plain write data
      em_rd_tag_t                rd_view;    // Read return tag
   } em_payload_u;

   // Full transaction with the MSB first
   typedef struct packed
   {
      logic                      write;      // 1 = write, 0 = read request
      logic [`EM_ADDR_W-1:0]     addr;       // Target address
      em_payload_u               payload;    // Data or tag
   } em_packet_t;

   // Packet width must agree with the macro used for FIFO sizing
   localparam int EM_PKT_BITS = $bits(em_packet_t);

endpackage

`default_nettype wire

//--- source/fifo_sync.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Small synchronous FIFO for one sorter lane
// Registered flags, distributed memory, async read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/10ps

module fifo_sync
#(
   parameter int DW = 16,                    // Data width
   parameter int AW = 5                      // Address width for 2**AW entries
)
(
   input  wire logic          clk,
   input  wire logic          reset,
   input  wire logic [DW-1:0] wr_data,
   input  wire logic          wr_en,         // Caller keeps this low when full
   input  wire logic          rd_en,         // Caller keeps this low when empty
   output logic      [DW-1:0] rd_data,
   output logic               rd_empty,
   output logic               wr_full
);

   logic [AW-1:0] wr_addr;                   // Next slot to write
   logic [AW-1:0] rd_addr;                   // Slot shown on rd_data
   logic [AW-1:0] count;                     // Wraps to 0 at full where wr_full tells apart

   logic [DW-1:0] mem [0:(2**AW)-1];         // Register array that maps to LUT RAM

   // Pointer, count and flag update
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_addr  <= '0;
         rd_addr  <= '0;
         count    <= '0;
         rd_empty <= 1'b1;
         wr_full  <= 1'b0;
      end
      else
      begin
         if (wr_en && rd_en)
         begin
            wr_addr <= wr_addr + 1'b1;       // Pass-through keeps the count
            rd_addr <= rd_addr + 1'b1;
         end
         else if (wr_en)
         begin
            wr_addr  <= wr_addr + 1'b1;
            count    <= count + 1'b1;
            rd_empty <= 1'b0;
            if (&count)
            begin
               wr_full <= 1'b1;              // Last free slot taken
            end
         end
         else if (rd_en)
         begin
            rd_addr <= rd_addr + 1'b1;
            count   <= count - 1'b1;
            wr_full <= 1'b0;
            if (count == AW'(1))
            begin
               rd_empty <= 1'b1;             // Last entry leaves
            end
         end
      end
   end

   // Storage written on the edge
   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         mem[wr_addr] <= wr_data;
      end
   end

   // Head of queue with no read latency
   assign rd_data = mem[rd_addr];

endmodule

`default_nettype wire

//--- source/lane_dispatch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Packet dispatcher that steers into FIFO lanes
// Writes by address, reads by requester id
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/10ps

`include "emesh_defines.svh"

module lane_dispatch import emesh_pkg::*;
(
   input  wire logic                  in_valid,
   output logic                       in_ready,
   input  wire em_packet_t            in_pkt,
   input  wire logic [`EM_LANES-1:0]  lane_full,      // wr_full of each lane
   output logic      [`EM_LANES-1:0]  lane_wr_en,     // One-hot and only on transfer
   output em_packet_t                 lane_wr_data    // Shared by all lanes
);

   logic [`EM_LANE_W-1:0] wr_lane;           // Lane from address bits
   logic [`EM_LANE_W-1:0] rd_lane;           // Lane from requester id
   logic [`EM_LANE_W-1:0] sel_lane;          // Lane this packet goes to
   logic [`EM_LANES-1:0]  sel_onehot;
   logic                  xfer;              // Handshake completes this edge

   // Writes interleave on an address field
   assign wr_lane = in_pkt.addr[`EM_LANE_SEL_LSB +: `EM_LANE_W];

   // Reads keep per-requester order so only the tag matters
   assign rd_lane = in_pkt.payload.rd_view.req_id[`EM_LANE_W-1:0];

   assign sel_lane = in_pkt.write ? wr_lane : rd_lane;

   // Decode to one-hot
   always_comb
   begin
      sel_onehot = '0;
      sel_onehot[sel_lane] = 1'b1;
   end

   // Back-pressure only from the targeted lane
   assign in_ready = ~lane_full[sel_lane];   // Does not look at in_valid

   assign xfer = in_valid & in_ready;

   assign lane_wr_en   = sel_onehot & {`EM_LANES{xfer}};   // Never set toward a full lane
   assign lane_wr_data = in_pkt;                            // Write enable picks the lane

endmodule

`default_nettype wire

//--- source/lane_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin drain of the FIFO lanes
// One registered output with valid/ready
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/10ps

`include "emesh_defines.svh"

module lane_arbiter import emesh_pkg::*;
(
   input  wire logic                              clk,
   input  wire logic                              reset,
   input  wire logic       [`EM_LANES-1:0]        lane_empty,
   input  wire em_packet_t [`EM_LANES-1:0]        lane_rd_data,   // Head of each lane
   output logic            [`EM_LANES-1:0]        lane_rd_en,     // One-hot pop
   output logic                                   out_valid,
   input  wire logic                              out_ready,
   output em_packet_t                             out_pkt
);

   logic [`EM_LANE_W-1:0] rr_ptr;            // Last lane served
   logic [`EM_LANE_W-1:0] grant_idx;         // Lane picked this cycle
   logic                  grant_found;       // Some lane has data
   logic                  load;              // Output register free this edge

   // Register is free if empty or being taken downstream
   assign load = ~out_valid | out_ready;

   // Search starts one past the pointer and wraps back to it
   always_comb
   begin : grant_search
      logic [`EM_LANE_W-1:0] cand;
      grant_found = 1'b0;
      grant_idx   = rr_ptr;
      cand        = rr_ptr;
      for (int i = 1; i <= `EM_LANES; i++)
      begin
         cand = rr_ptr + `EM_LANE_W'(i);     // i = EM_LANES wraps to rr_ptr
         if (!grant_found && !lane_empty[cand])
         begin
            grant_found = 1'b1;
            grant_idx   = cand;
         end
      end
   end

   // Pop only a non-empty lane and only when the register takes it
   always_comb
   begin
      lane_rd_en = '0;
      if (load && grant_found)
      begin
         lane_rd_en[grant_idx] = 1'b1;
      end
   end

   // Valid flag and round-robin pointer
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         out_valid <= 1'b0;
         rr_ptr    <= `EM_LANE_W'(`EM_LANES - 1);   // Lane 0 gets first turn
      end
      else if (load)
      begin
         out_valid <= grant_found;           // Drops when all lanes are dry
         if (grant_found)
         begin
            rr_ptr <= grant_idx;
         end
      end
   end

   // Payload register held while stalled
   always_ff @(posedge clk)
   begin
      if (load && grant_found)
      begin
         out_pkt <= lane_rd_data[grant_idx];
      end
   end

endmodule

`default_nettype wire

//--- source/emesh_sorter_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// eMesh transaction sorter top level
// Dispatcher, FIFO lanes and round-robin arbiter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/10ps

`include "emesh_defines.svh"

module emesh_sorter_top import emesh_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        reset,
   input  wire logic        in_valid,
   output logic             in_ready,
   input  wire em_packet_t  in_pkt,
   output logic             out_valid,
   input  wire logic        out_ready,
   output em_packet_t       out_pkt
);

   logic       [`EM_LANES-1:0] lane_wr_en;      // Dispatcher to lanes
   em_packet_t                 lane_wr_data;
   logic       [`EM_LANES-1:0] lane_full;
   logic       [`EM_LANES-1:0] lane_rd_en;      // Arbiter to lanes
   logic       [`EM_LANES-1:0] lane_empty;
   em_packet_t [`EM_LANES-1:0] lane_rd_data;

   lane_dispatch u_dispatch
   (
      .in_valid     (in_valid),
      .in_ready     (in_ready),
      .in_pkt       (in_pkt),
      .lane_full    (lane_full),
      .lane_wr_en   (lane_wr_en),
      .lane_wr_data (lane_wr_data)
   );

   // One FIFO per lane on a shared data bus
   for (genvar g = 0; g < `EM_LANES; g++)
   begin : g_lane
      fifo_sync
      #(
         .DW (`EM_PKT_W),
         .AW (`EM_FIFO_AW)
      )
      u_fifo
      (
         .clk      (clk),
         .reset    (reset),
         .wr_data  (lane_wr_data),
         .wr_en    (lane_wr_en[g]),
         .rd_en    (lane_rd_en[g]),
         .rd_data  (lane_rd_data[g]),
         .rd_empty (lane_empty[g]),
         .wr_full  (lane_full[g])
      );
   end

   lane_arbiter u_arbiter
   (
      .clk          (clk),
      .reset        (reset),
      .lane_empty   (lane_empty),
      .lane_rd_data (lane_rd_data),
      .lane_rd_en   (lane_rd_en),
      .out_valid    (out_valid),
      .out_ready    (out_ready),
      .out_pkt      (out_pkt)
   );

endmodule

`default_nettype wire

//--- sim/emesh_sorter_asserts.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sorter assertions on FIFO protection and output hold
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/10ps

`include "emesh_defines.svh"

module emesh_sorter_asserts
(
   input wire logic                 clk,
   input wire logic                 reset,
   input wire logic [`EM_LANES-1:0] lane_wr_en,   // One bit per fifo_sync
   input wire logic [`EM_LANES-1:0] lane_full,
   input wire logic [`EM_LANES-1:0] lane_rd_en,
   input wire logic [`EM_LANES-1:0] lane_empty,
   input wire logic                 out_valid,
   input wire logic                 out_ready,
   input wire logic [`EM_PKT_W-1:0] out_pkt
);

   int fail_count = 0;                       // Read by the testbench at the end

   // No lane FIFO is written while full
   no_write_on_full : assert property (@(posedge clk) disable iff (reset)
      (lane_wr_en & lane_full) == '0)
   else
   begin
      $error("FIFO lane written while full");
      fail_count++;
   end

   // No lane FIFO is read while empty
   no_read_on_empty : assert property (@(posedge clk) disable iff (reset)
      (lane_rd_en & lane_empty) == '0)
   else
   begin
      $error("FIFO lane read while empty");
      fail_count++;
   end

   // Stalled output holds its packet
   out_hold : assert property (@(posedge clk) disable iff (reset)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_pkt)))
   else
   begin
      $error("out_pkt changed or dropped while stalled");
      fail_count++;
   end

endmodule

// Lane buses at the top reach every fifo_sync instance
bind emesh_sorter_top emesh_sorter_asserts u_asserts
(
   .clk        (clk),
   .reset      (reset),
   .lane_wr_en (lane_wr_en),
   .lane_full  (lane_full),
   .lane_rd_en (lane_rd_en),
   .lane_empty (lane_empty),
   .out_valid  (out_valid),
   .out_ready  (out_ready),
   .out_pkt    (out_pkt)
);

`default_nettype wire

//--- sim/tb_emesh_sorter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the eMesh transaction sorter
// Random traffic, per-lane reference queues, stalls
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none
`timescale 1ns/10ps

`include "emesh_defines.svh"

module tb_emesh_sorter import emesh_pkg::*; ();

   localparam int N_RANDOM  = 200;           // Mixed traffic without stalls
   localparam int N_SAME_ID = 16;            // Reads from one requester
   localparam int N_FILL    = 33;            // One lane plus output register
   localparam int N_MIXED   = 400;           // Long run with random stalls
   localparam int N_TOTAL   = N_RANDOM + N_SAME_ID + N_FILL + N_MIXED;
   localparam int WATCHDOG_CYCLES = N_TOTAL * 20 + 500;

   logic       clk = 1'b0;
   logic       reset;
   logic       in_valid;
   logic       in_ready;
   em_packet_t in_pkt;
   logic       out_valid;
   logic       out_ready;
   em_packet_t out_pkt;

   logic       ready_random;                 // Random out_ready when set
   logic       ready_level;                  // Fixed out_ready otherwise
   integer     seed = 83;                    // Stimulus stream
   integer     ready_seed = 83 + 1000;       // Separate stream for out_ready
   int         errors;
   int         in_count;
   int         out_count;

   em_packet_t lane_q [`EM_LANES][$];        // Expected order per lane

   always #4 clk = ~clk;                     // 8 ns period

   emesh_sorter_top dut
   (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_pkt    (in_pkt),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_pkt   (out_pkt)
   );

   // Writes go by address field, reads by the top bits of the payload tag
   function automatic logic [`EM_LANE_W-1:0] expected_lane(input em_packet_t p);
      if (p.write)
      begin
         return `EM_LANE_W'((p.addr >> `EM_LANE_SEL_LSB) % `EM_LANES);
      end
      return `EM_LANE_W'((p.payload.wr_view >> (`EM_PAYLOAD_W - `EM_REQ_ID_W)) % `EM_LANES);
   endfunction

   task automatic check_value(input string name, input logic [`EM_PKT_W-1:0] actual,
                              input logic [`EM_PKT_W-1:0] expected);
      if (actual !== expected)
      begin
         $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, actual, expected);
         errors++;
      end
   endtask

   // Compare on output transfers and record on input transfers
   always @(posedge clk)
   begin : scoreboard
      em_packet_t            exp_pkt;
      logic [`EM_LANE_W-1:0] lane;
      if (!reset && out_valid && out_ready)
      begin
         lane = expected_lane(out_pkt);
         out_count++;
         if (lane_q[lane].size() == 0)
         begin
            $display("Output packet %h at %0t has no pending packet in lane %0d",
                     out_pkt, $time, lane);
            errors++;
         end
         else
         begin
            exp_pkt = lane_q[lane].pop_front();
            check_value("out_pkt", out_pkt, exp_pkt);
         end
      end
      if (!reset && in_valid && in_ready)
      begin
         lane_q[expected_lane(in_pkt)].push_back(in_pkt);
         in_count++;
      end
   end

   // Downstream ready changes 1 ns after the edge
   initial
   begin
      out_ready = 1'b0;
      forever
      begin
         @(posedge clk);
         #1;
         if (ready_random)
         begin
            out_ready = ($random(ready_seed) & 3) != 0;   // About 3 in 4 cycles
         end
         else
         begin
            out_ready = ready_level;
         end
      end
   end

   initial
   begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
      $display("Simulation failed");
      $finish;
   end

   task automatic random_packet(output em_packet_t p);
      p.write   = 1'($random(seed));
      p.addr    = $random(seed);
      p.payload = $random(seed);
   endtask

   // Hold the packet until the DUT takes it
   task automatic send_packet(input em_packet_t p);
      in_pkt   = p;
      in_valid = 1'b1;
      @(posedge clk);
      while (!in_ready)
      begin
         @(posedge clk);
      end
      #1;
      in_valid = 1'b0;
   endtask

   task automatic wait_drain();
      while (out_count != in_count)
      begin
         @(posedge clk);
         #1;
      end
   endtask

   initial
   begin : main
      em_packet_t pkt;
      errors       = 0;
      in_count     = 0;
      out_count    = 0;
      reset        = 1'b1;
      in_valid     = 1'b0;
      in_pkt       = '0;
      ready_random = 1'b0;
      ready_level  = 1'b1;
      repeat (5) @(posedge clk);
      #1;
      reset = 1'b0;

      check_value("out_valid", `EM_PKT_W'(out_valid), '0);   // Idle after reset
      check_value("in_ready", `EM_PKT_W'(in_ready), `EM_PKT_W'(1));
      check_value("packet width", `EM_PKT_W'(EM_PKT_BITS), `EM_PKT_W'(`EM_PKT_W));

      for (int i = 0; i < N_RANDOM; i++)
      begin
         random_packet(pkt);
         send_packet(pkt);
      end
      wait_drain();

      // Same requester behind a stalled output
      // Address field walks the lanes downward so address steering would reorder
      ready_random = 1'b0;
      ready_level  = 1'b0;
      for (int i = 0; i < N_SAME_ID; i++)
      begin
         random_packet(pkt);
         pkt.write = 1'b0;
         pkt.addr[`EM_LANE_SEL_LSB +: `EM_LANE_W] = `EM_LANE_W'(`EM_LANES - 1 - i);
         pkt.payload.rd_view.req_id = `EM_REQ_ID_W'(5);
         send_packet(pkt);
      end
      ready_level = 1'b1;
      wait_drain();

      // Stall the output and fill lane 2
      ready_random = 1'b0;
      ready_level  = 1'b0;
      @(posedge clk);
      #1;
      for (int i = 0; i < N_FILL; i++)
      begin
         random_packet(pkt);
         pkt.write = 1'b1;
         pkt.addr[`EM_LANE_SEL_LSB +: `EM_LANE_W] = `EM_LANE_W'(2);
         send_packet(pkt);
      end
      random_packet(pkt);
      pkt.write = 1'b1;
      pkt.addr[`EM_LANE_SEL_LSB +: `EM_LANE_W] = `EM_LANE_W'(2);
      in_pkt = pkt;                          // Shown but not offered
      repeat (2) @(posedge clk);
      #1;
      check_value("in_ready", `EM_PKT_W'(in_ready), '0);
      check_value("out_valid", `EM_PKT_W'(out_valid), `EM_PKT_W'(1));
      ready_level = 1'b1;
      wait_drain();

      ready_random = 1'b1;
      for (int i = 0; i < N_MIXED; i++)
      begin
         random_packet(pkt);
         send_packet(pkt);
      end
      wait_drain();

      for (int i = 0; i < `EM_LANES; i++)
      begin
         check_value($sformatf("lane %0d queue depth", i), `EM_PKT_W'(lane_q[i].size()), '0);
      end
      check_value("packets in", `EM_PKT_W'(in_count), `EM_PKT_W'(N_TOTAL));
      check_value("packets out", `EM_PKT_W'(out_count), `EM_PKT_W'(N_TOTAL));
      check_value("out_valid", `EM_PKT_W'(out_valid), '0);
      errors += dut.u_asserts.fail_count;    // Bound assertion failures

      $display("Errors: %0d (assertions %0d), packets in %0d, packets out %0d",
               errors, dut.u_asserts.fail_count, in_count, out_count);
      if (errors == 0)
      begin
         $display("Simulation completed successfully");
      end
      else
      begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
source/emesh_pkg.sv
source/fifo_sync.sv
source/lane_dispatch.sv
source/lane_arbiter.sv
source/emesh_sorter_top.sv
sim/emesh_sorter_asserts.sv
sim/tb_emesh_sorter.sv

//--- Makefile
# Verilator build and run for the eMesh sorter testbench

VERILATOR ?= verilator
TOP       ?= tb_emesh_sorter
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Simulation completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source, a header or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
